//--- ccl_top.f
+incdir+testbench
design/ccl_geom_pkg.sv
design/ccl_feat_pkg.sv
design/line_buffer.sv
design/window_3x3.sv
design/first_pass_labeler.sv
design/label_slot.sv
design/feature_readout.sv
design/ccl_top.sv
testbench/tb_ccl_top.sv

//--- design/ccl_feat_pkg.sv
// label count, area limit and the label and feature field types
package ccl_feat_pkg;

    // label 0 is background, labels 1..NUM_LABELS own one slot each
    localparam int NUM_LABELS = 15;

    // a blob above this many pixels is flagged not ok
    localparam int MAX_AREA = 40;

    typedef logic [3:0] label_t;

    typedef logic [7:0] area_t;     // saturates at all ones

    typedef logic [8:0] perim_t;    // running sum of per-pixel increments

    // background neighbours of one pixel, 0 to 4
    typedef logic [2:0] incr_t;

endpackage

//--- design/ccl_geom_pkg.sv
// image size, foreground level and coordinate and pixel types
package ccl_geom_pkg;

    // frame geometry
    localparam int IMG_W = 16;      // pixels per line
    localparam int IMG_H = 12;      // lines per frame

    // binary input, only full white is object
    localparam int FG_LEVEL = 255;

    // column index, wide enough for IMG_W-1
    typedef logic [3:0] x_t;

    // row index, also holds IMG_H during the flush line
    typedef logic [3:0] y_t;

    typedef logic [7:0] pix_t;      // raw input pixel

endpackage

//--- design/ccl_top.sv
// labeler top with window, first pass, feature slots and readout
module ccl_top (
    input  logic                 clk,
    input  logic                 rst_fifo,
    input  logic                 vsync_i,
    input  logic                 href_i,
    input  ccl_geom_pkg::pix_t   pix_i,
    output logic                 feat_valid_o,
    output ccl_feat_pkg::label_t feat_label_o,
    output ccl_feat_pkg::area_t  feat_area_o,
    output ccl_feat_pkg::perim_t feat_perim_o,
    output ccl_geom_pkg::x_t     feat_xmin_o,
    output ccl_geom_pkg::x_t     feat_xmax_o,
    output ccl_geom_pkg::y_t     feat_ymin_o,
    output ccl_geom_pkg::y_t     feat_ymax_o,
    output logic                 feat_ok_o,
    output logic                 frame_done_o
);
    import ccl_geom_pkg::*;
    import ccl_feat_pkg::*;

    // window stream
    logic win_valid;
    logic win_c;
    logic win_l;
    logic win_r;
    logic win_u;
    logic win_d;
    x_t   win_x;
    y_t   win_y;
    logic win_last;

    // slot update bus
    logic [NUM_LABELS-1:0] upd_en;
    x_t                    upd_x;
    y_t                    upd_y;
    incr_t                 upd_incr;
    logic                  clear;
    label_t                label_count;
    logic                  frame_end;

    // slot results
    area_t  slot_area  [NUM_LABELS];
    perim_t slot_perim [NUM_LABELS];
    x_t     slot_xmin  [NUM_LABELS];
    x_t     slot_xmax  [NUM_LABELS];
    y_t     slot_ymin  [NUM_LABELS];
    y_t     slot_ymax  [NUM_LABELS];
    logic   slot_ok    [NUM_LABELS];

    window_3x3 i_window (
        .clk         (clk),
        .rst_fifo    (rst_fifo),
        .vsync_i     (vsync_i),
        .href_i      (href_i),
        .pix_i       (pix_i),
        .win_valid_o (win_valid),
        .win_c_o     (win_c),
        .win_l_o     (win_l),
        .win_r_o     (win_r),
        .win_u_o     (win_u),
        .win_d_o     (win_d),
        .win_x_o     (win_x),
        .win_y_o     (win_y),
        .win_last_o  (win_last)
    );

    first_pass_labeler i_labeler (
        .clk           (clk),
        .rst_fifo      (rst_fifo),
        .vsync_i       (vsync_i),
        .win_valid_i   (win_valid),
        .win_c_i       (win_c),
        .win_l_i       (win_l),
        .win_r_i       (win_r),
        .win_u_i       (win_u),
        .win_d_i       (win_d),
        .win_x_i       (win_x),
        .win_y_i       (win_y),
        .win_last_i    (win_last),
        .upd_en_o      (upd_en),
        .upd_x_o       (upd_x),
        .upd_y_o       (upd_y),
        .upd_incr_o    (upd_incr),
        .clear_o       (clear),
        .label_count_o (label_count),
        .frame_end_o   (frame_end)
    );

    for (genvar i = 0; i < NUM_LABELS; i++) begin : g_slot  // slot i owns label i+1
        label_slot i_slot (
            .clk        (clk),
            .rst_fifo   (rst_fifo),
            .clear_i    (clear),
            .upd_en_i   (upd_en[i]),
            .upd_x_i    (upd_x),
            .upd_y_i    (upd_y),
            .upd_incr_i (upd_incr),
            .area_o     (slot_area[i]),
            .perim_o    (slot_perim[i]),
            .xmin_o     (slot_xmin[i]),
            .xmax_o     (slot_xmax[i]),
            .ymin_o     (slot_ymin[i]),
            .ymax_o     (slot_ymax[i]),
            .ok_o       (slot_ok[i])
        );
    end

    feature_readout i_readout (
        .clk           (clk),
        .rst_fifo      (rst_fifo),
        .frame_end_i   (frame_end),
        .label_count_i (label_count),
        .area_i        (slot_area),
        .perim_i       (slot_perim),
        .xmin_i        (slot_xmin),
        .xmax_i        (slot_xmax),
        .ymin_i        (slot_ymin),
        .ymax_i        (slot_ymax),
        .ok_i          (slot_ok),
        .feat_valid_o  (feat_valid_o),
        .feat_label_o  (feat_label_o),
        .feat_area_o   (feat_area_o),
        .feat_perim_o  (feat_perim_o),
        .feat_xmin_o   (feat_xmin_o),
        .feat_xmax_o   (feat_xmax_o),
        .feat_ymin_o   (feat_ymin_o),
        .feat_ymax_o   (feat_ymax_o),
        .feat_ok_o     (feat_ok_o),
        .frame_done_o  (frame_done_o)
    );

endmodule

//--- design/feature_readout.sv
// end-of-frame scan of the used slots into one feature record per cycle
module feature_readout (
    input  logic                 clk,
    input  logic                 rst_fifo,
    input  logic                 frame_end_i,
    input  ccl_feat_pkg::label_t label_count_i,
    input  ccl_feat_pkg::area_t  area_i  [ccl_feat_pkg::NUM_LABELS],
    input  ccl_feat_pkg::perim_t perim_i [ccl_feat_pkg::NUM_LABELS],
    input  ccl_geom_pkg::x_t     xmin_i  [ccl_feat_pkg::NUM_LABELS],
    input  ccl_geom_pkg::x_t     xmax_i  [ccl_feat_pkg::NUM_LABELS],
    input  ccl_geom_pkg::y_t     ymin_i  [ccl_feat_pkg::NUM_LABELS],
    input  ccl_geom_pkg::y_t     ymax_i  [ccl_feat_pkg::NUM_LABELS],
    input  logic                 ok_i    [ccl_feat_pkg::NUM_LABELS],
    output logic                 feat_valid_o,
    output ccl_feat_pkg::label_t feat_label_o,
    output ccl_feat_pkg::area_t  feat_area_o,
    output ccl_feat_pkg::perim_t feat_perim_o,
    output ccl_geom_pkg::x_t     feat_xmin_o,
    output ccl_geom_pkg::x_t     feat_xmax_o,
    output ccl_geom_pkg::y_t     feat_ymin_o,
    output ccl_geom_pkg::y_t     feat_ymax_o,
    output logic                 feat_ok_o,
    output logic                 frame_done_o
);
    import ccl_feat_pkg::*;

    logic   busy;
    logic   tail;   // last record out, done follows
    label_t idx;    // label being read
    label_t slot;

    assign slot = idx - 1'b1;

    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            busy         <= 1'b0;
            tail         <= 1'b0;
            idx          <= '0;
            feat_valid_o <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            feat_valid_o <= 1'b0;
            frame_done_o <= tail;
            tail         <= 1'b0;
            if (frame_end_i) begin
                busy <= 1'b1;
                idx  <= label_t'(1);
            end else if (busy) begin
                if (label_count_i == '0) begin  // empty frame
                    busy         <= 1'b0;
                    frame_done_o <= 1'b1;
                end else begin
                    feat_valid_o <= 1'b1;
                    idx          <= idx + 1'b1;
                    if (idx == label_count_i) begin
                        busy <= 1'b0;
                        tail <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            feat_label_o <= idx;
            feat_area_o  <= area_i[slot];
            feat_perim_o <= perim_i[slot];
            feat_xmin_o  <= xmin_i[slot];
            feat_xmax_o  <= xmax_i[slot];
            feat_ymin_o  <= ymin_i[slot];
            feat_ymax_o  <= ymax_i[slot];
            feat_ok_o    <= ok_i[slot];
        end
    end

    a_no_overlap_scan: assert property (@(posedge clk) disable iff (rst_fifo)
        frame_end_i |-> !(busy || tail));

endmodule

//--- design/first_pass_labeler.sv
// first-pass label assignment, perimeter increment and slot update strobes
module first_pass_labeler (
    input  logic                                 clk,
    input  logic                                 rst_fifo,
    input  logic                                 vsync_i,
    input  logic                                 win_valid_i,
    input  logic                                 win_c_i,
    input  logic                                 win_l_i,
    input  logic                                 win_r_i,
    input  logic                                 win_u_i,
    input  logic                                 win_d_i,
    input  ccl_geom_pkg::x_t                     win_x_i,
    input  ccl_geom_pkg::y_t                     win_y_i,
    input  logic                                 win_last_i,
    output logic [ccl_feat_pkg::NUM_LABELS-1:0]  upd_en_o,
    output ccl_geom_pkg::x_t                     upd_x_o,
    output ccl_geom_pkg::y_t                     upd_y_o,
    output ccl_feat_pkg::incr_t                  upd_incr_o,
    output logic                                 clear_o,
    output ccl_feat_pkg::label_t                 label_count_o,
    output logic                                 frame_end_o
);
    import ccl_geom_pkg::*;
    import ccl_feat_pkg::*;

    logic   vsync_d;
    logic   p_valid;        // window registered while the above label is read
    logic   p_last;
    logic   p_c;
    logic   p_l;
    logic   p_r;
    logic   p_u;
    logic   p_d;
    x_t     p_x;
    y_t     p_y;
    label_t above_rd;
    label_t left_lab;       // label of the previous pixel in the row
    label_t left_use;
    label_t above_use;
    label_t cur_lab;
    logic   room;
    logic   opens_new;
    incr_t  incr;

    line_buffer #(.payload_t(label_t)) i_label_line (
        .clk       (clk),
        .wr_en_i   (p_valid),
        .wr_addr_i (p_x),
        .wr_data_i (cur_lab),
        .rd_addr_i (win_x_i),
        .rd_data_o (above_rd)
    );

    // stale labels only matter where the neighbour is foreground
    assign left_use  = p_l ? left_lab : '0;
    assign above_use = p_u ? above_rd : '0;
    assign room      = label_count_o < label_t'(NUM_LABELS);
    assign opens_new = p_c && left_use == '0 && above_use == '0 && room;

    always_comb begin
        cur_lab = '0;
        if (p_c) begin
            if (left_use == '0 && above_use == '0) begin
                cur_lab = room ? label_count_o + 1'b1 : '0;  // 0 once exhausted
            end else if (left_use == '0) begin
                cur_lab = above_use;
            end else if (above_use == '0 || left_use < above_use) begin
                cur_lab = left_use;
            end else begin
                cur_lab = above_use;
            end
        end
    end

    assign incr = incr_t'(!p_l) + incr_t'(!p_r) + incr_t'(!p_u) + incr_t'(!p_d);

    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            vsync_d       <= 1'b0;
            clear_o       <= 1'b0;
            p_valid       <= 1'b0;
            p_last        <= 1'b0;
            frame_end_o   <= 1'b0;
            upd_en_o      <= '0;
            label_count_o <= '0;
        end else begin
            vsync_d     <= vsync_i;
            clear_o     <= vsync_i && !vsync_d;  // frame start
            p_valid     <= win_valid_i;
            p_last      <= win_valid_i && win_last_i;
            frame_end_o <= p_last;
            upd_en_o    <= '0;
            if (p_valid && cur_lab != '0) begin
                upd_en_o[cur_lab - 1'b1] <= 1'b1;
            end
            if (clear_o) begin
                label_count_o <= '0;
            end else if (p_valid && opens_new) begin
                label_count_o <= cur_lab;
            end
        end
    end

    always_ff @(posedge clk) begin
        p_c        <= win_c_i;
        p_l        <= win_l_i;
        p_r        <= win_r_i;
        p_u        <= win_u_i;
        p_d        <= win_d_i;
        p_x        <= win_x_i;
        p_y        <= win_y_i;
        upd_x_o    <= p_x;
        upd_y_o    <= p_y;
        upd_incr_o <= incr;
        if (p_valid) begin
            left_lab <= cur_lab;
        end
    end

    // a strobe only ever targets a label that is already open
    a_upd_opened: assert property (@(posedge clk) disable iff (rst_fifo)
        (upd_en_o >> label_count_o) == '0);

endmodule

//--- design/label_slot.sv
// per-label accumulator for area, perimeter, bounding box and area ok flag
module label_slot (
    input  logic                 clk,
    input  logic                 rst_fifo,
    input  logic                 clear_i,
    input  logic                 upd_en_i,
    input  ccl_geom_pkg::x_t     upd_x_i,
    input  ccl_geom_pkg::y_t     upd_y_i,
    input  ccl_feat_pkg::incr_t  upd_incr_i,
    output ccl_feat_pkg::area_t  area_o,
    output ccl_feat_pkg::perim_t perim_o,
    output ccl_geom_pkg::x_t     xmin_o,
    output ccl_geom_pkg::x_t     xmax_o,
    output ccl_geom_pkg::y_t     ymin_o,
    output ccl_geom_pkg::y_t     ymax_o,
    output logic                 ok_o
);
    import ccl_feat_pkg::*;

    logic first;  // slot still empty this frame

    assign first = area_o == '0;

    always_ff @(posedge clk) begin
        if (rst_fifo || clear_i) begin
            area_o  <= '0;
            perim_o <= '0;
            ok_o    <= 1'b1;
        end else if (upd_en_i) begin
            if (area_o != '1) begin
                area_o <= area_o + 1'b1;
            end
            perim_o <= perim_o + perim_t'(upd_incr_i);
            if (area_o >= area_t'(MAX_AREA)) begin  // new area passes the limit
                ok_o <= 1'b0;
            end
        end
    end

    // first pixel loads the box, later ones widen it
    always_ff @(posedge clk) begin
        if (upd_en_i) begin
            if (first || upd_x_i < xmin_o) begin
                xmin_o <= upd_x_i;
            end
            if (first || upd_x_i > xmax_o) begin
                xmax_o <= upd_x_i;
            end
            if (first || upd_y_i < ymin_o) begin
                ymin_o <= upd_y_i;
            end
            if (first || upd_y_i > ymax_o) begin
                ymax_o <= upd_y_i;
            end
        end
    end

    a_clear_no_upd: assert property (@(posedge clk) disable iff (rst_fifo)
        !(clear_i && upd_en_i));

endmodule

//--- design/line_buffer.sv
// single-line delay memory with registered read and a generic payload type
module line_buffer #(
    parameter type payload_t = logic
) (
    input  logic             clk,
    input  logic             wr_en_i,
    input  ccl_geom_pkg::x_t wr_addr_i,
    input  payload_t         wr_data_i,
    input  ccl_geom_pkg::x_t rd_addr_i,
    output payload_t         rd_data_o
);
    import ccl_geom_pkg::*;

    payload_t mem [IMG_W];  // one entry per column

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // same-address read returns the old entry
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- design/window_3x3.sv
// neighbour window generator with row buffers, edge masking and last-line flush
module window_3x3 (
    input  logic               clk,
    input  logic               rst_fifo,
    input  logic               vsync_i,
    input  logic               href_i,
    input  ccl_geom_pkg::pix_t pix_i,
    output logic               win_valid_o,
    output logic               win_c_o,
    output logic               win_l_o,
    output logic               win_r_o,
    output logic               win_u_o,
    output logic               win_d_o,
    output ccl_geom_pkg::x_t   win_x_o,
    output ccl_geom_pkg::y_t   win_y_o,
    output logic               win_last_o
);
    import ccl_geom_pkg::*;

    logic vsync_d;
    logic flushing;         // self-timed line after vsync falls
    logic act;
    logic cur_fg;
    x_t   in_x;
    y_t   in_y;

    // stage 1 holds column x of rows y, y-1 and y-2
    logic s1_act;
    logic s1_tail;          // extra step after the last column
    logic s1_cur;
    x_t   s1_x;
    y_t   s1_y;
    logic mid_q;
    logic up_q;

    // previous two columns with the centre in c2
    logic c2_cur;
    logic c2_mid;
    logic c2_up;
    logic c1_mid;

    logic emit;
    logic col_left;
    logic row_top;
    x_t   cx;

    assign act    = href_i | flushing;
    assign cur_fg = href_i && (pix_i == pix_t'(FG_LEVEL));  // flush row is background

    line_buffer #(.payload_t(logic)) i_mid_line (
        .clk       (clk),
        .wr_en_i   (act),
        .wr_addr_i (in_x),
        .wr_data_i (cur_fg),
        .rd_addr_i (in_x),
        .rd_data_o (mid_q)
    );

    // row y-2 fed from the mid buffer output one cycle later
    line_buffer #(.payload_t(logic)) i_up_line (
        .clk       (clk),
        .wr_en_i   (s1_act),
        .wr_addr_i (s1_x),
        .wr_data_i (mid_q),
        .rd_addr_i (in_x),
        .rd_data_o (up_q)
    );

    assign emit     = ((s1_act && s1_x != '0) || s1_tail) && s1_y != '0;
    assign col_left = !s1_tail && s1_x == x_t'(1);
    assign row_top  = s1_y == y_t'(1);
    assign cx       = s1_tail ? x_t'(IMG_W - 1) : s1_x - 1'b1;

    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            vsync_d     <= 1'b0;
            flushing    <= 1'b0;
            in_x        <= '0;
            in_y        <= '0;
            s1_act      <= 1'b0;
            s1_tail     <= 1'b0;
            win_valid_o <= 1'b0;
            win_last_o  <= 1'b0;
        end else begin
            vsync_d <= vsync_i;
            if (vsync_d && !vsync_i) begin
                flushing <= 1'b1;
            end
            if (act) begin
                in_x <= in_x + 1'b1;
                if (in_x == x_t'(IMG_W - 1)) begin
                    in_x <= '0;
                    in_y <= in_y + 1'b1;
                    if (flushing) begin  // frame finished
                        in_y     <= '0;
                        flushing <= 1'b0;
                    end
                end
            end
            s1_act      <= act;
            s1_tail     <= s1_act && s1_x == x_t'(IMG_W - 1);
            win_valid_o <= emit;
            win_last_o  <= emit && s1_tail && s1_y == y_t'(IMG_H);
        end
    end

    always_ff @(posedge clk) begin
        s1_cur <= cur_fg;
        if (act) begin  // held through the tail step
            s1_x <= in_x;
            s1_y <= in_y;
        end
        if (s1_act) begin
            c2_cur <= s1_cur;
            c2_mid <= mid_q;
            c2_up  <= up_q;
            c1_mid <= c2_mid;
        end
        win_c_o <= c2_mid;
        win_l_o <= col_left ? 1'b0 : c1_mid;
        win_r_o <= s1_tail ? 1'b0 : mid_q;
        win_u_o <= row_top ? 1'b0 : c2_up;
        win_d_o <= c2_cur;
        win_x_o <= cx;
        win_y_o <= s1_y - 1'b1;
    end

    a_no_href_in_flush: assert property (@(posedge clk) disable iff (rst_fifo)
        flushing |-> !href_i);

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the labeler testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_ccl_top \
    -f ccl_top.f \
    -o sim_ccl
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ccl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
echo "run_sim: pass message not found"
exit 1

//--- testbench/ccl_model.svh
// frame storage, frame builders and the reference first-pass feature model
`ifndef CCL_MODEL_SVH
`define CCL_MODEL_SVH

pix_t frame_pix [IMG_H][IMG_W];     // frame being sent
int   lab_img   [IMG_H][IMG_W];     // model labels, 0 where unlabeled

// expected records, entry i belongs to label i+1
int exp_count = 0;
int exp_area  [NUM_LABELS];
int exp_perim [NUM_LABELS];
int exp_xmin  [NUM_LABELS];
int exp_xmax  [NUM_LABELS];
int exp_ymin  [NUM_LABELS];
int exp_ymax  [NUM_LABELS];
int exp_ok    [NUM_LABELS];

function automatic void clear_frame();
    for (int y = 0; y < IMG_H; y++) begin
        for (int x = 0; x < IMG_W; x++) begin
            frame_pix[y][x] = pix_t'((x * 7 + y * 13) % 200);  // dark, never white
        end
    end
endfunction

function automatic void fill_rect(input int x0, input int y0, input int w, input int h);
    for (int y = y0; y < y0 + h; y++) begin
        for (int x = x0; x < x0 + w; x++) begin
            frame_pix[y][x] = pix_t'(FG_LEVEL);
        end
    end
endfunction

// isolated pixels on the even squares
function automatic void fill_checker();
    for (int y = 0; y < IMG_H; y++) begin
        for (int x = 0; x < IMG_W; x++) begin
            if ((x + y) % 2 == 0) begin
                frame_pix[y][x] = pix_t'(FG_LEVEL);
            end
        end
    end
endfunction

function automatic bit is_fg(input int x, input int y);
    if (x < 0 || x >= IMG_W || y < 0 || y >= IMG_H) begin
        return 1'b0;  // outside the image
    end
    return frame_pix[y][x] == pix_t'(FG_LEVEL);
endfunction

function automatic void add_pixel(input int i, input int x, input int y);
    int incr;
    incr = 0;
    if (!is_fg(x - 1, y)) incr++;
    if (!is_fg(x + 1, y)) incr++;
    if (!is_fg(x, y - 1)) incr++;
    if (!is_fg(x, y + 1)) incr++;
    if (exp_area[i] == 0) begin
        exp_xmin[i] = x;
        exp_xmax[i] = x;
        exp_ymin[i] = y;
        exp_ymax[i] = y;
    end else begin
        exp_xmin[i] = (x < exp_xmin[i]) ? x : exp_xmin[i];
        exp_xmax[i] = (x > exp_xmax[i]) ? x : exp_xmax[i];
        exp_ymin[i] = (y < exp_ymin[i]) ? y : exp_ymin[i];
        exp_ymax[i] = (y > exp_ymax[i]) ? y : exp_ymax[i];
    end
    if (exp_area[i] < (1 << $bits(area_t)) - 1) begin
        exp_area[i]++;  // saturating count
    end
    exp_perim[i] = (exp_perim[i] + incr) % (1 << $bits(perim_t));
    exp_ok[i] = (exp_area[i] <= MAX_AREA) ? 1 : 0;
endfunction

// raster-order labeling from left and above, no merging
function automatic void compute_features();
    int left;
    int up;
    int lab;
    exp_count = 0;
    for (int i = 0; i < NUM_LABELS; i++) begin
        exp_area[i] = 0;
        exp_perim[i] = 0;
        exp_ok[i] = 1;
    end
    for (int y = 0; y < IMG_H; y++) begin
        for (int x = 0; x < IMG_W; x++) begin
            lab = 0;
            if (is_fg(x, y)) begin
                left = (x > 0) ? lab_img[y][x - 1] : 0;
                up = (y > 0) ? lab_img[y - 1][x] : 0;
                if (left == 0 && up == 0) begin
                    if (exp_count < NUM_LABELS) begin  // exhausted pixels stay 0
                        exp_count++;
                        lab = exp_count;
                    end
                end else if (left == 0 || (up != 0 && up < left)) begin
                    lab = up;
                end else begin
                    lab = left;
                end
            end
            lab_img[y][x] = lab;
            if (lab != 0) begin
                add_pixel(lab - 1, x, y);
            end
        end
    end
endfunction

`endif

//--- testbench/tb_ccl_top.sv
// testbench for the labeler top with frame stimulus, record compare and timeout
module tb_ccl_top;
    import ccl_geom_pkg::*;
    import ccl_feat_pkg::*;

    localparam int NUM_FRAMES = 11;
    localparam int LIMIT = NUM_FRAMES * ((IMG_H + 2) * (IMG_W + 8) + NUM_LABELS + 100);

    logic   clk;
    logic   rst_fifo;
    logic   vsync;
    logic   href;
    pix_t   pix;
    logic   feat_valid;
    label_t feat_label;
    area_t  feat_area;
    perim_t feat_perim;
    x_t     feat_xmin;
    x_t     feat_xmax;
    y_t     feat_ymin;
    y_t     feat_ymax;
    logic   feat_ok;
    logic   frame_done;

    int seed;
    int cycles = 0;
    int rec_idx = 0;        // records seen in the current frame
    int field_errors = 0;
    int count_errors = 0;
    int model_errors = 0;
    int timeout_errors = 0;

    `include "ccl_model.svh"

    ccl_top i_dut (
        .clk          (clk),
        .rst_fifo     (rst_fifo),
        .vsync_i      (vsync),
        .href_i       (href),
        .pix_i        (pix),
        .feat_valid_o (feat_valid),
        .feat_label_o (feat_label),
        .feat_area_o  (feat_area),
        .feat_perim_o (feat_perim),
        .feat_xmin_o  (feat_xmin),
        .feat_xmax_o  (feat_xmax),
        .feat_ymin_o  (feat_ymin),
        .feat_ymax_o  (feat_ymax),
        .feat_ok_o    (feat_ok),
        .frame_done_o (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic end_run();
        int total;
        total = field_errors + count_errors + model_errors + timeout_errors;
        $display("errors: field %0d, record count %0d, model %0d, timeout %0d",
                 field_errors, count_errors, model_errors, timeout_errors);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic compare_field(input string field, input int got, input int want);
        if (got != want) begin
            $display("FAILED %0t: label %0d %s is %0d, expected %0d",
                     $time, rec_idx + 1, field, got, want);
            field_errors++;
        end
    endtask

    // one frame with the framing of a sensor, then wait for the readout to finish
    task automatic send_frame();
        compute_features();
        vsync = 1'b1;
        repeat (4) @(negedge clk);
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                href = 1'b1;
                pix = frame_pix[y][x];
                @(negedge clk);
            end
            href = 1'b0;
            pix = pix_t'(FG_LEVEL);  // ignored while href is low
            repeat (4) @(negedge clk);
        end
        repeat (IMG_W + 8) @(negedge clk);
        vsync = 1'b0;
        @(posedge clk);
        while (!frame_done) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic fill_random(input int density);
        int r;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                r = $random(seed);
                if (int'(r[1:0]) < density) begin
                    frame_pix[y][x] = pix_t'(FG_LEVEL);
                end else begin
                    frame_pix[y][x] = r[15:8] & 8'hfe;  // 254 at most
                end
            end
        end
    endtask

    // records arrive in label order, checked against the model tables
    always @(posedge clk) begin
        if (feat_valid) begin
            if (rec_idx >= exp_count) begin
                $display("unexpected record for label %0d at %0t, only %0d expected",
                         feat_label, $time, exp_count);
                count_errors++;
            end else begin
                compare_field("label", int'(feat_label), rec_idx + 1);
                compare_field("area", int'(feat_area), exp_area[rec_idx]);
                compare_field("perimeter", int'(feat_perim), exp_perim[rec_idx]);
                compare_field("xmin", int'(feat_xmin), exp_xmin[rec_idx]);
                compare_field("xmax", int'(feat_xmax), exp_xmax[rec_idx]);
                compare_field("ymin", int'(feat_ymin), exp_ymin[rec_idx]);
                compare_field("ymax", int'(feat_ymax), exp_ymax[rec_idx]);
                compare_field("ok", int'(feat_ok), exp_ok[rec_idx]);
            end
            rec_idx++;
        end
        if (frame_done) begin
            if (rec_idx < exp_count) begin
                $display("frame done at %0t after %0d of %0d records",
                         $time, rec_idx, exp_count);
                count_errors++;
            end
            rec_idx = 0;
        end
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles", cycles);
        timeout_errors++;
        end_run();
    end

    initial begin
        seed = 32'h0fec_09b5;
        rst_fifo = 1'b1;
        vsync = 1'b0;
        href = 1'b0;
        pix = '0;
        repeat (8) @(negedge clk);
        rst_fifo = 1'b0;
        repeat (2) @(negedge clk);

        clear_frame();
        fill_rect(5, 4, 4, 3);  // solid 4x3 block
        send_frame();
        if (exp_count != 1 || exp_area[0] != 12 || exp_perim[0] != 14) begin
            $display("model gives %0d records, area %0d, perimeter %0d for the block",
                     exp_count, exp_area[0], exp_perim[0]);
            model_errors++;
        end

        clear_frame();
        fill_rect(0, 0, 3, 2);   // on the border
        fill_rect(10, 2, 2, 2);
        fill_rect(4, 8, 5, 2);
        fill_rect(15, 11, 1, 1); // bottom right corner
        send_frame();

        // U shape, the right arm keeps its own label
        clear_frame();
        fill_rect(3, 2, 1, 5);
        fill_rect(7, 2, 1, 5);
        fill_rect(3, 6, 5, 1);
        send_frame();
        if (exp_count != 2) begin
            $display("model gives %0d labels for the U shape", exp_count);
            model_errors++;
        end

        clear_frame();
        fill_rect(0, 0, 7, 6);   // 42 pixels
        fill_rect(8, 6, 8, 5);   // exactly 40
        send_frame();
        if (exp_ok[0] != 0 || exp_ok[1] != 1) begin
            $display("model ok flags %0d and %0d around the area limit", exp_ok[0], exp_ok[1]);
            model_errors++;
        end

        clear_frame();
        fill_checker();
        send_frame();
        if (exp_count != NUM_LABELS) begin
            $display("model opens %0d labels on the checkerboard", exp_count);
            model_errors++;
        end

        clear_frame();  // nothing to label
        send_frame();

        for (int k = 0; k < 5; k++) begin
            fill_random(1 + k % 3);
            send_frame();
        end

        end_run();
    end

endmodule
